// File: src/wbm_arb_pkg.sv
`default_nettype none

package wbm_arb_pkg;

  localparam int NUM_MASTERS = 4;
  localparam int MASTER_ID_W = 2; // enough bits to index NUM_MASTERS
  localparam int ADR_W       = 16;
  localparam int DAT_W       = 16;
  localparam int RAM_ADR_W   = 8; // ram sits where adr[15:8] == 0

  // request as seen by the shared slave port
  typedef struct packed {
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat; // write data
  } wb_req_t;

  // response from whichever slave answered
  typedef struct packed {
    logic             ack;
    logic             err;
    logic [DAT_W-1:0] dat; // read data
  } wb_rsp_t;

  typedef enum logic [0:0] {
    ARB_IDLE = 1'b0,
    ARB_BUSY = 1'b1
  } arb_state_e;

endpackage

`default_nettype wire

// File: src/wbm_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wbm_arbiter (
  input  wire                                         wb_clk_i,
  input  wire                                         wb_rst_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]         wbm_cyc_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]         wbm_stb_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]         wbm_mask_i,
  input  wbm_arb_pkg::wb_rsp_t                        slv_rsp_i,
  output logic                                        slv_stb_o,
  output logic [wbm_arb_pkg::MASTER_ID_W-1:0]         grant_id_o
);

  logic [wbm_arb_pkg::NUM_MASTERS-1:0] pending;
  logic [wbm_arb_pkg::NUM_MASTERS-1:0] bits_to_set;
  logic [wbm_arb_pkg::NUM_MASTERS-1:0] bit_to_clear;
  logic [wbm_arb_pkg::NUM_MASTERS-1:0] next_pending;
  logic [wbm_arb_pkg::MASTER_ID_W-1:0] next_grant;
  logic                                rsp_valid;
  logic                                issue;
  wbm_arb_pkg::arb_state_e             state;

  // highest-numbered pending master wins
  function automatic logic [wbm_arb_pkg::MASTER_ID_W-1:0] pick_master(
    input logic [wbm_arb_pkg::NUM_MASTERS-1:0] req
  );
    logic [wbm_arb_pkg::MASTER_ID_W-1:0] id;
    id = '0;
    for (int i = 0; i < wbm_arb_pkg::NUM_MASTERS; i++) begin
      if (req[i]) begin
        id = i[wbm_arb_pkg::MASTER_ID_W-1:0];
      end
    end
    return id;
  endfunction

  assign rsp_valid   = slv_rsp_i.ack | slv_rsp_i.err;
  assign bits_to_set = wbm_cyc_i & wbm_stb_i & wbm_mask_i;

  always_comb begin
    bit_to_clear             = '0;
    bit_to_clear[grant_id_o] = rsp_valid; // only the granted transfer ends
  end

  // a new request on the same master keeps its bit set
  assign next_pending = (pending & ~bit_to_clear) | bits_to_set;
  assign next_grant   = pick_master(next_pending);

  // bus is free when idle or when the current transfer ends this cycle
  assign issue = ((state == wbm_arb_pkg::ARB_IDLE) || rsp_valid) && (|next_pending);

  always_ff @(posedge wb_clk_i) begin
    slv_stb_o <= 1'b0; // strobe is a single-cycle pulse
    if (wb_rst_i) begin
      pending    <= '0;
      grant_id_o <= '0;
      state      <= wbm_arb_pkg::ARB_IDLE;
    end else begin
      pending <= next_pending;
      if (issue) begin
        grant_id_o <= next_grant; // held until the response comes back
        slv_stb_o  <= 1'b1;
        state      <= wbm_arb_pkg::ARB_BUSY;
      end else if (rsp_valid) begin
        state <= wbm_arb_pkg::ARB_IDLE;
      end
    end
  end

  // slave needs a cycle to answer before the next strobe can go out
  a_stb_gap: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    slv_stb_o |=> !slv_stb_o
  ) else $error("slave strobe high in two consecutive cycles");

  a_rsp_busy: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    rsp_valid |-> (state == wbm_arb_pkg::ARB_BUSY)
  ) else $error("slave response with no transfer outstanding");

endmodule

`default_nettype wire

// File: src/wbm_req_mux.sv
`timescale 1ns/1ps
`default_nettype none

module wbm_req_mux (
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_we_i,
  input  wire  [wbm_arb_pkg::ADR_W*wbm_arb_pkg::NUM_MASTERS-1:0] wbm_adr_i,
  input  wire  [wbm_arb_pkg::DAT_W*wbm_arb_pkg::NUM_MASTERS-1:0] wbm_dat_i,
  input  wire  [wbm_arb_pkg::MASTER_ID_W-1:0]                   grant_id_i,
  input  wbm_arb_pkg::wb_rsp_t                                  slv_rsp_i,
  output wbm_arb_pkg::wb_req_t                                  slv_req_o,
  output logic [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_ack_o,
  output logic [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_err_o,
  output logic [wbm_arb_pkg::DAT_W-1:0]                         wbm_dat_o
);

  // request of the granted master goes to the slave port
  always_comb begin
    slv_req_o.we  = wbm_we_i[grant_id_i];
    slv_req_o.adr = wbm_adr_i[grant_id_i*wbm_arb_pkg::ADR_W +: wbm_arb_pkg::ADR_W];
    slv_req_o.dat = wbm_dat_i[grant_id_i*wbm_arb_pkg::DAT_W +: wbm_arb_pkg::DAT_W];
  end

  // ack and err go back to the granted master only
  always_comb begin
    wbm_ack_o             = '0;
    wbm_err_o             = '0;
    wbm_ack_o[grant_id_i] = slv_rsp_i.ack;
    wbm_err_o[grant_id_i] = slv_rsp_i.err;
  end

  assign wbm_dat_o = slv_rsp_i.dat; // read data is broadcast

endmodule

`default_nettype wire

// File: src/wbs_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module wbs_decoder (
  input  wire                  wb_clk_i,
  input  wire                  wb_rst_i,
  input  wire                  slv_stb_i,
  input  wbm_arb_pkg::wb_req_t slv_req_i,
  input  wbm_arb_pkg::wb_rsp_t ram_rsp_i,
  output logic                 ram_stb_o,
  output wbm_arb_pkg::wb_rsp_t slv_rsp_o
);

  logic ram_sel;
  logic err_q;

  // ram occupies the bottom page only
  assign ram_sel = (slv_req_i.adr[wbm_arb_pkg::ADR_W-1:wbm_arb_pkg::RAM_ADR_W] == '0);

  assign ram_stb_o = slv_stb_i & ram_sel;

  // unmapped access answers with err one cycle after the strobe as the ram does
  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      err_q <= 1'b0;
    end else begin
      err_q <= slv_stb_i & ~ram_sel;
    end
  end

  always_comb begin
    slv_rsp_o.ack = ram_rsp_i.ack;
    slv_rsp_o.err = ram_rsp_i.err | err_q;
    slv_rsp_o.dat = ram_rsp_i.dat;
  end

  a_ack_err_excl: assert property (
    @(posedge wb_clk_i) disable iff (wb_rst_i)
    !(slv_rsp_o.ack && slv_rsp_o.err)
  ) else $error("ack and err raised together");

endmodule

`default_nettype wire

// File: src/wb_ram.sv
`timescale 1ns/1ps
`default_nettype none

module wb_ram (
  input  wire                  wb_clk_i,
  input  wire                  wb_rst_i,
  input  wire                  stb_i,
  input  wbm_arb_pkg::wb_req_t req_i,
  output wbm_arb_pkg::wb_rsp_t rsp_o
);

  logic [wbm_arb_pkg::DAT_W-1:0]     mem [2**wbm_arb_pkg::RAM_ADR_W];
  logic [wbm_arb_pkg::RAM_ADR_W-1:0] word_adr;
  logic [wbm_arb_pkg::DAT_W-1:0]     rd_q;
  logic                              ack_q;

  assign word_adr = req_i.adr[wbm_arb_pkg::RAM_ADR_W-1:0];

  always_ff @(posedge wb_clk_i) begin
    if (stb_i) begin
      if (req_i.we) begin
        mem[word_adr] <= req_i.dat;
      end
      rd_q <= mem[word_adr]; // old contents on a write
    end
  end

  always_ff @(posedge wb_clk_i) begin
    if (wb_rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= stb_i;
    end
  end

  always_comb begin
    rsp_o.ack = ack_q;
    rsp_o.err = 1'b0; // every word in range is valid
    rsp_o.dat = rd_q;
  end

endmodule

`default_nettype wire

// File: src/wb_arb_top.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arb_top (
  input  wire                                                   wb_clk_i,
  input  wire                                                   wb_rst_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_cyc_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_stb_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_we_i,
  input  wire  [wbm_arb_pkg::ADR_W*wbm_arb_pkg::NUM_MASTERS-1:0] wbm_adr_i,
  input  wire  [wbm_arb_pkg::DAT_W*wbm_arb_pkg::NUM_MASTERS-1:0] wbm_dat_i,
  input  wire  [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_mask_i,
  output logic [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_ack_o,
  output logic [wbm_arb_pkg::NUM_MASTERS-1:0]                   wbm_err_o,
  output logic [wbm_arb_pkg::DAT_W-1:0]                         wbm_dat_o,
  output logic [wbm_arb_pkg::MASTER_ID_W-1:0]                   wbm_id_o
);

  logic                                slv_stb;
  logic [wbm_arb_pkg::MASTER_ID_W-1:0] grant_id;
  wbm_arb_pkg::wb_req_t                slv_req;
  wbm_arb_pkg::wb_rsp_t                slv_rsp;
  wbm_arb_pkg::wb_rsp_t                ram_rsp;
  logic                                ram_stb;

  assign wbm_id_o = grant_id;

  wbm_arbiter u_arbiter (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_mask_i (wbm_mask_i),
    .slv_rsp_i  (slv_rsp),
    .slv_stb_o  (slv_stb),
    .grant_id_o (grant_id)
  );

  wbm_req_mux u_req_mux (
    .wbm_we_i   (wbm_we_i),
    .wbm_adr_i  (wbm_adr_i),
    .wbm_dat_i  (wbm_dat_i),
    .grant_id_i (grant_id),
    .slv_rsp_i  (slv_rsp),
    .slv_req_o  (slv_req),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_err_o  (wbm_err_o),
    .wbm_dat_o  (wbm_dat_o)
  );

  wbs_decoder u_decoder (
    .wb_clk_i  (wb_clk_i),
    .wb_rst_i  (wb_rst_i),
    .slv_stb_i (slv_stb),
    .slv_req_i (slv_req),
    .ram_rsp_i (ram_rsp),
    .ram_stb_o (ram_stb),
    .slv_rsp_o (slv_rsp)
  );

  wb_ram u_ram (
    .wb_clk_i (wb_clk_i),
    .wb_rst_i (wb_rst_i),
    .stb_i    (ram_stb),
    .req_i    (slv_req),
    .rsp_o    (ram_rsp)
  );

endmodule

`default_nettype wire

// File: verif/tb_wb_arb.sv
`timescale 1ns/1ps
`default_nettype none

module tb_wb_arb;

  localparam int CLK_PERIOD   = 40;
  localparam int XFER_TIMEOUT = 20;
  localparam int RANDOM_OPS   = 40;
  localparam int NM           = wbm_arb_pkg::NUM_MASTERS;
  localparam int AW           = wbm_arb_pkg::ADR_W;
  localparam int DW           = wbm_arb_pkg::DAT_W;
  // reset, write/read, unmapped, masking, priority, random
  localparam int TEST_CYCLES  = 7 + 8 * 3 + 4 * 3 + 17 + 25 + RANDOM_OPS * 3;
  localparam int WATCHDOG_CYCLES = 2 * TEST_CYCLES + 50;

  logic             wb_clk_i;
  logic             wb_rst_i;
  logic [NM-1:0]    wbm_cyc_i;
  logic [NM-1:0]    wbm_stb_i;
  logic [NM-1:0]    wbm_we_i;
  logic [AW*NM-1:0] wbm_adr_i;
  logic [DW*NM-1:0] wbm_dat_i;
  logic [NM-1:0]    wbm_mask_i;
  logic [NM-1:0]    wbm_ack_o;
  logic [NM-1:0]    wbm_err_o;
  logic [DW-1:0]    wbm_dat_o;
  logic [wbm_arb_pkg::MASTER_ID_W-1:0] wbm_id_o;

  // response seen by the last do_transfer call
  logic          xfer_ack;
  logic          xfer_err;
  logic [DW-1:0] xfer_rdat;
  logic [NM-1:0] xfer_ack_vec;
  logic [NM-1:0] xfer_err_vec;
  int            xfer_lat;

  logic [DW-1:0] ref_mem [256];
  bit            ref_valid [256];
  int            err_cnt;
  int            tests_passed;
  int            tests_failed;

  wb_arb_top dut (
    .wb_clk_i   (wb_clk_i),
    .wb_rst_i   (wb_rst_i),
    .wbm_cyc_i  (wbm_cyc_i),
    .wbm_stb_i  (wbm_stb_i),
    .wbm_we_i   (wbm_we_i),
    .wbm_adr_i  (wbm_adr_i),
    .wbm_dat_i  (wbm_dat_i),
    .wbm_mask_i (wbm_mask_i),
    .wbm_ack_o  (wbm_ack_o),
    .wbm_err_o  (wbm_err_o),
    .wbm_dat_o  (wbm_dat_o),
    .wbm_id_o   (wbm_id_o)
  );

  initial wb_clk_i = 1'b0;
  always #(CLK_PERIOD / 2) wb_clk_i = ~wb_clk_i;

  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("FAIL %0t %s got %h expected %h", $time, sig, got, exp);
    err_cnt++;
  endtask

  task automatic ref_write(input logic [AW-1:0] adr, input logic [DW-1:0] dat);
    ref_mem[adr[7:0]]   = dat;
    ref_valid[adr[7:0]] = 1'b1;
  endtask

  // called and returns 2 ns after a rising edge
  task automatic do_transfer(input int m, input logic we, input logic [AW-1:0] adr,
                             input logic [DW-1:0] wdat);
    xfer_ack = 1'b0;
    xfer_err = 1'b0;
    xfer_lat = 0;
    wbm_we_i[m]              = we;
    wbm_adr_i[m*AW +: AW]    = adr;
    wbm_dat_i[m*DW +: DW]    = wdat;
    wbm_cyc_i[m]             = 1'b1;
    wbm_stb_i[m]             = 1'b1;
    @(posedge wb_clk_i); // samples the request
    while (!xfer_ack && !xfer_err && xfer_lat < XFER_TIMEOUT) begin
      #1;
      xfer_lat++;
      xfer_ack     = wbm_ack_o[m];
      xfer_err     = wbm_err_o[m];
      xfer_ack_vec = wbm_ack_o;
      xfer_err_vec = wbm_err_o;
      xfer_rdat    = wbm_dat_o;
      #1;
      wbm_cyc_i[m] = 1'b0; // the pending bit holds the one-cycle request
      wbm_stb_i[m] = 1'b0;
      if (!xfer_ack && !xfer_err) begin
        @(posedge wb_clk_i);
      end
    end
    if (!xfer_ack && !xfer_err) begin
      $display("master %0d got no ack or err within %0d cycles for address %h",
               m, XFER_TIMEOUT, adr);
      err_cnt++;
      #2;
    end
  endtask

  task automatic check_response(input int m, input logic expect_err);
    logic [NM-1:0] own;
    own    = '0;
    own[m] = 1'b1;
    if (expect_err) begin
      if (xfer_ack_vec != '0) report_mismatch("wbm_ack_o", 32'(xfer_ack_vec), 32'(0));
      if (xfer_err_vec != own) report_mismatch("wbm_err_o", 32'(xfer_err_vec), 32'(own));
    end else begin
      if (xfer_ack_vec != own) report_mismatch("wbm_ack_o", 32'(xfer_ack_vec), 32'(own));
      if (xfer_err_vec != '0) report_mismatch("wbm_err_o", 32'(xfer_err_vec), 32'(0));
    end
  endtask

  task automatic finish_test(input string name, input int start_err);
    if (err_cnt == start_err) begin
      tests_passed++;
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, err_cnt - start_err);
    end
  endtask

  task automatic test_write_read();
    int            start;
    logic [AW-1:0] adr;
    logic [DW-1:0] wdat;
    start = err_cnt;
    for (int m = 0; m < NM; m++) begin
      adr  = 16'h0040 + 16'(m);
      wdat = 16'h3c00 + 16'(m * 257);
      do_transfer(m, 1'b1, adr, wdat);
      check_response(m, 1'b0);
      if (xfer_lat != 2) report_mismatch("write ack latency", xfer_lat, 2);
      ref_write(adr, wdat);
      do_transfer(m, 1'b0, adr, 16'h0000);
      check_response(m, 1'b0);
      if (xfer_lat != 2) report_mismatch("read ack latency", xfer_lat, 2);
      if (xfer_rdat != ref_mem[adr[7:0]])
        report_mismatch("wbm_dat_o", 32'(xfer_rdat), 32'(ref_mem[adr[7:0]]));
    end
    finish_test("write_read", start);
  endtask

  task automatic test_unmapped();
    int start;
    start = err_cnt;
    do_transfer(2, 1'b1, 16'h0034, 16'h1357);
    check_response(2, 1'b0);
    ref_write(16'h0034, 16'h1357);
    do_transfer(2, 1'b1, 16'h1234, 16'hdead); // aliases word 0x34 if decoding were wrong
    check_response(2, 1'b1);
    do_transfer(0, 1'b0, 16'h1234, 16'h0000);
    check_response(0, 1'b1);
    do_transfer(2, 1'b0, 16'h0034, 16'h0000);
    check_response(2, 1'b0);
    if (xfer_rdat != ref_mem[8'h34])
      report_mismatch("wbm_dat_o", 32'(xfer_rdat), 32'(ref_mem[8'h34]));
    finish_test("unmapped", start);
  endtask

  task automatic test_masking();
    int start;
    start = err_cnt;
    wbm_mask_i[1]        = 1'b0;
    wbm_we_i[1]          = 1'b1;
    wbm_adr_i[AW +: AW]  = 16'h0020;
    wbm_dat_i[DW +: DW]  = 16'hbad0;
    wbm_cyc_i[1]         = 1'b1;
    wbm_stb_i[1]         = 1'b1;
    for (int n = 0; n < 10; n++) begin
      @(posedge wb_clk_i);
      #1;
      if (wbm_ack_o[1] || wbm_err_o[1]) begin
        $display("masked master 1 received a response at %0t", $time);
        err_cnt++;
      end
      #1;
    end
    wbm_cyc_i[1]  = 1'b0;
    wbm_stb_i[1]  = 1'b0;
    wbm_mask_i[1] = 1'b1;
    @(posedge wb_clk_i);
    #2;
    do_transfer(1, 1'b1, 16'h0020, 16'h600d);
    check_response(1, 1'b0);
    ref_write(16'h0020, 16'h600d);
    do_transfer(1, 1'b0, 16'h0020, 16'h0000);
    check_response(1, 1'b0);
    if (xfer_rdat != ref_mem[8'h20])
      report_mismatch("wbm_dat_o", 32'(xfer_rdat), 32'(ref_mem[8'h20]));
    finish_test("masking", start);
  endtask

  task automatic test_priority();
    int start;
    int n;
    int order[$];
    int acks [NM];
    start = err_cnt;
    for (int m = 0; m < NM; m++) begin
      acks[m]               = 0;
      wbm_we_i[m]           = 1'b1;
      wbm_adr_i[m*AW +: AW] = 16'h0080 + 16'(m);
      wbm_dat_i[m*DW +: DW] = 16'h7000 + 16'(m);
    end
    wbm_cyc_i = '1;
    wbm_stb_i = '1;
    @(posedge wb_clk_i); // all four sampled on the same edge
    #2;
    wbm_cyc_i = '0;
    wbm_stb_i = '0;
    n = 0;
    while (order.size() < NM && n < XFER_TIMEOUT * NM) begin
      @(posedge wb_clk_i);
      #1;
      n++;
      if (!$onehot0(wbm_ack_o)) begin
        $display("more than one master acknowledged at %0t", $time);
        err_cnt++;
      end
      if (wbm_err_o != '0) report_mismatch("wbm_err_o", 32'(wbm_err_o), 32'(0));
      for (int m = 0; m < NM; m++) begin
        if (wbm_ack_o[m]) begin
          order.push_back(m);
          acks[m]++;
          if (int'(wbm_id_o) != m) report_mismatch("wbm_id_o", 32'(wbm_id_o), m);
        end
      end
      #1;
    end
    repeat (3) begin // catch a duplicate ack
      @(posedge wb_clk_i);
      #1;
      for (int m = 0; m < NM; m++) begin
        if (wbm_ack_o[m]) acks[m]++;
      end
      #1;
    end
    if (order.size() != NM) begin
      $display("only %0d of %0d contending masters were acknowledged", order.size(), NM);
      err_cnt++;
    end else begin
      for (int i = 0; i < NM; i++) begin
        if (order[i] != NM - 1 - i) report_mismatch("ack order", order[i], NM - 1 - i);
      end
    end
    for (int m = 0; m < NM; m++) begin
      if (acks[m] != 1) report_mismatch($sformatf("ack count master %0d", m), acks[m], 1);
      ref_write(16'h0080 + 16'(m), 16'h7000 + 16'(m));
    end
    finish_test("priority", start);
  endtask

  task automatic test_random();
    int            start;
    int            m;
    logic          we;
    logic [7:0]    word;
    logic [DW-1:0] wdat;
    start = err_cnt;
    for (int k = 0; k < RANDOM_OPS; k++) begin
      m    = $urandom_range(NM - 1, 0);
      word = 8'($urandom_range(255, 224)); // small window so reads hit written words
      wdat = 16'($urandom);
      we   = ($urandom_range(1, 0) == 1) || !ref_valid[word];
      do_transfer(m, we, {8'h00, word}, wdat);
      check_response(m, 1'b0);
      if (we) begin
        ref_write({8'h00, word}, wdat);
      end else if (xfer_rdat != ref_mem[word]) begin
        report_mismatch("wbm_dat_o", 32'(xfer_rdat), 32'(ref_mem[word]));
      end
    end
    finish_test("random", start);
  endtask

  initial begin
    void'($urandom(32'h8fac0bf2));
    wb_rst_i     = 1'b1;
    wbm_cyc_i    = '0;
    wbm_stb_i    = '0;
    wbm_we_i     = '0;
    wbm_adr_i    = '0;
    wbm_dat_i    = '0;
    wbm_mask_i   = '1;
    err_cnt      = 0;
    tests_passed = 0;
    tests_failed = 0;
    repeat (5) @(posedge wb_clk_i);
    #2;
    wb_rst_i = 1'b0;
    @(posedge wb_clk_i);
    #2;
    test_write_read();
    test_unmapped();
    test_masking();
    test_priority();
    test_random();
    $display("tests: %0d passed, %0d failed", tests_passed, tests_failed);
    if (tests_failed == 0 && err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, tests did not finish", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
src/wbm_arb_pkg.sv
src/wbm_arbiter.sv
src/wbm_req_mux.sv
src/wbs_decoder.sv
src/wb_ram.sv
src/wb_arb_top.sv
verif/tb_wb_arb.sv

// File: Makefile
# Verilator build and run of the Wishbone arbiter testbench

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module tb_wb_arb -f flist.f -o Vtb_wb_arb

run: compile
	@out=$$(./obj_dir/Vtb_wb_arb); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir
